// ==== sobel_pkg.sv ====
package sobel_pkg;

  // frame geometry, kept small for quick runs
  localparam int IMG_W = 16;                // pixels per row, also line FIFO depth
  localparam int IMG_H = 8;                 // rows per frame
  localparam int COL_W = $clog2(IMG_W);     // column counter / FIFO pointer width
  localparam int ROW_W = $clog2(IMG_H);     // row counter width

  // one grayscale sample
  typedef logic [7:0] pixel_t;

  // vertical slice of the 3x3 window, all at the same column
  typedef struct packed {
    pixel_t top;                            // two rows back
    pixel_t mid;                            // previous row
    pixel_t bot;                            // current row
  } column_t;

  // gradient range is +-1020, needs 11 bits signed
  typedef logic signed [10:0] grad_t;

  // |gx| + |gy| tops out at 2040
  typedef logic [10:0] mag_t;

  // runtime settings for the kernel
  typedef struct packed {
    pixel_t threshold;                      // edge when magnitude >= this
    logic   edge_white;                     // 1 swaps edge and background colours
  } edge_cfg_t;

  localparam pixel_t DEF_THRESHOLD = 8'd12; // threshold out of reset

  // output colours
  localparam pixel_t BLACK = 8'h00;
  localparam pixel_t WHITE = 8'hff;

  // config register map, 1-bit address
  localparam logic CFG_ADDR_THRESH = 1'b0;
  localparam logic CFG_ADDR_MODE   = 1'b1;

endpackage

// ==== line_fifo.sv ====
`timescale 1ns/1ns
module line_fifo import sobel_pkg::*;
(
  input  logic   sys_clk,
  input  logic   sys_rst_n,
  input  logic   clear,      // sync flush, wins over rd/wr
  input  logic   wr_en,
  input  pixel_t din,
  input  logic   rd_en,
  output pixel_t dout,       // head entry, no read latency
  output logic   full,
  output logic   empty
);

  pixel_t           mem [IMG_W];  // one row of storage
  logic [COL_W-1:0] wr_ptr;
  logic [COL_W-1:0] rd_ptr;
  logic [COL_W:0]   count;        // occupancy 0..IMG_W
  logic             do_wr;
  logic             do_rd;

  assign full  = (count == (COL_W + 1)'(IMG_W));
  assign empty = (count == '0);
  assign do_wr = wr_en && !full;  // overflow dropped
  assign do_rd = rd_en && !empty;
  assign dout  = mem[rd_ptr];     // show-ahead

  always_ff @(posedge sys_clk)
  begin
    if (do_wr)
      mem[wr_ptr] <= din;
  end

  // pointers and count
  always_ff @(posedge sys_clk or negedge sys_rst_n)
  begin
    if (!sys_rst_n)
    begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end
    else if (clear)
    begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end
    else
    begin
      if (do_wr)
        wr_ptr <= (wr_ptr == COL_W'(IMG_W - 1)) ? '0 : wr_ptr + 1'b1;
      if (do_rd)
        rd_ptr <= (rd_ptr == COL_W'(IMG_W - 1)) ? '0 : rd_ptr + 1'b1;
      case ({do_wr, do_rd})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;   // idle or both, level unchanged
      endcase
    end
  end

endmodule

// ==== line_buffer.sv ====
`timescale 1ns/1ns
module line_buffer import sobel_pkg::*;
(
  input  logic    sys_clk,
  input  logic    sys_rst_n,
  input  pixel_t  pix_in,
  input  logic    pix_valid,   // one strobe per pixel, raster order
  output column_t col,         // top/mid/bot at the current column
  output logic    col_valid    // one cycle after pix_valid, rows 2 and up
);

  logic [COL_W-1:0] col_cnt;     // column of the incoming pixel
  logic [ROW_W-1:0] row_cnt;     // row of the incoming pixel
  logic             last_col;
  logic             frame_start; // pixel (0,0) of a frame
  logic             rd_mid;
  logic             rd_top;
  logic             mid_wr;
  logic             top_wr;
  pixel_t           mid_din;
  pixel_t           top_din;
  pixel_t           mid_dout;
  pixel_t           top_dout;

  assign last_col    = (col_cnt == COL_W'(IMG_W - 1));
  assign frame_start = pix_valid && (col_cnt == '0) && (row_cnt == '0);
  assign rd_mid      = pix_valid && (row_cnt != '0);       // previous row exists
  assign rd_top      = pix_valid && (row_cnt >= ROW_W'(2)); // full window height

  // raster position
  always_ff @(posedge sys_clk or negedge sys_rst_n)
  begin
    if (!sys_rst_n)
    begin
      col_cnt <= '0;
      row_cnt <= '0;
    end
    else if (pix_valid)
    begin
      col_cnt <= last_col ? '0 : col_cnt + 1'b1;
      if (last_col)
        row_cnt <= (row_cnt == ROW_W'(IMG_H - 1)) ? '0 : row_cnt + 1'b1;
    end
  end

  // FIFO writes land one cycle after the strobe, after that slot's read
  // so a write never meets a full FIFO; last row feeds nothing
  always_ff @(posedge sys_clk or negedge sys_rst_n)
  begin
    if (!sys_rst_n)
    begin
      mid_wr    <= 1'b0;
      top_wr    <= 1'b0;
      col_valid <= 1'b0;
    end
    else
    begin
      mid_wr    <= pix_valid && (row_cnt <= ROW_W'(IMG_H - 2));
      top_wr    <= rd_mid && (row_cnt <= ROW_W'(IMG_H - 2)); // mid head moves up
      col_valid <= rd_top;
    end
  end

  always_ff @(posedge sys_clk)
  begin
    if (pix_valid)
    begin
      mid_din <= pix_in;
      top_din <= mid_dout;
    end
    if (rd_top)
      col <= '{top: top_dout, mid: mid_dout, bot: pix_in};
  end

  // previous row
  line_fifo fifo_mid (
    .sys_clk   (sys_clk),
    .sys_rst_n (sys_rst_n),
    .clear     (frame_start),
    .wr_en     (mid_wr),
    .din       (mid_din),
    .rd_en     (rd_mid),
    .dout      (mid_dout),
    .full      (),
    .empty     ()
  );

  // two rows back
  line_fifo fifo_top (
    .sys_clk   (sys_clk),
    .sys_rst_n (sys_rst_n),
    .clear     (frame_start),
    .wr_en     (top_wr),
    .din       (top_din),
    .rd_en     (rd_top),
    .dout      (top_dout),
    .full      (),
    .empty     ()
  );

endmodule

// ==== sobel_kernel.sv ====
`timescale 1ns/1ns
module sobel_kernel import sobel_pkg::*;
(
  input  logic      sys_clk,
  input  logic      sys_rst_n,
  input  column_t   col,        // newest column, right side of the window
  input  logic      col_valid,
  input  edge_cfg_t cfg,
  output pixel_t    pix_out,
  output logic      out_valid   // col_valid + 3
);

  column_t          win_l;      // leftmost column
  column_t          win_m;      // centre column
  logic [COL_W-1:0] kcol;       // column index within the row
  logic             win_full;
  grad_t            gx_c;
  grad_t            gy_c;
  grad_t            gx;
  grad_t            gy;
  logic             grad_valid;
  mag_t             mag;
  logic             mag_valid;
  pixel_t           edge_pix;
  pixel_t           back_pix;

  // a + 2b + c, zero extended into the signed range
  function automatic grad_t wsum(pixel_t a, pixel_t b, pixel_t c);
    return grad_t'({3'b000, a}) + grad_t'({2'b00, b, 1'b0}) + grad_t'({3'b000, c});
  endfunction

  function automatic mag_t abs_g(grad_t g);
    return g[10] ? mag_t'(-g) : mag_t'(g);
  endfunction

  assign win_full = (kcol >= COL_W'(2)); // two older columns already held
  assign gx_c     = wsum(win_l.top, win_l.mid, win_l.bot) - wsum(col.top, col.mid, col.bot);
  assign gy_c     = wsum(win_l.top, win_m.top, col.top) - wsum(win_l.bot, win_m.bot, col.bot);
  assign edge_pix = cfg.edge_white ? WHITE : BLACK;
  assign back_pix = cfg.edge_white ? BLACK : WHITE;

  // control: column count and stage strobes
  always_ff @(posedge sys_clk or negedge sys_rst_n)
  begin
    if (!sys_rst_n)
    begin
      kcol       <= '0;
      grad_valid <= 1'b0;
      mag_valid  <= 1'b0;
      out_valid  <= 1'b0;
    end
    else
    begin
      if (col_valid)
        kcol <= (kcol == COL_W'(IMG_W - 1)) ? '0 : kcol + 1'b1;
      grad_valid <= col_valid && win_full;
      mag_valid  <= grad_valid;
      out_valid  <= mag_valid;
    end
  end

  // datapath
  always_ff @(posedge sys_clk)
  begin
    if (col_valid)
    begin
      win_l <= win_m;   // shift left by one column
      win_m <= col;
      gx    <= gx_c;
      gy    <= gy_c;
    end
    if (grad_valid)
      mag <= abs_g(gx) + abs_g(gy);
    if (mag_valid)
      pix_out <= (mag >= mag_t'(cfg.threshold)) ? edge_pix : back_pix;
  end

endmodule

// ==== edge_cfg_regs.sv ====
`timescale 1ns/1ns
module edge_cfg_regs import sobel_pkg::*;
(
  input  logic      sys_clk,
  input  logic      sys_rst_n,
  input  logic      cfg_we,     // write strobe
  input  logic      cfg_addr,   // 0 threshold, 1 mode
  input  pixel_t    cfg_wdata,
  output edge_cfg_t cfg         // straight to the kernel
);

  // decoded writes land on the next clock
  always_ff @(posedge sys_clk or negedge sys_rst_n)
  begin
    if (!sys_rst_n)
    begin
      cfg.threshold  <= DEF_THRESHOLD;
      cfg.edge_white <= 1'b0;        // black edges on white by default
    end
    else if (cfg_we)
    begin
      case (cfg_addr)
        CFG_ADDR_THRESH:
          cfg.threshold <= cfg_wdata;
        CFG_ADDR_MODE:
          cfg.edge_white <= cfg_wdata[0]; // upper bits ignored
      endcase
    end
  end

endmodule

// ==== sobel_top.sv ====
`timescale 1ns/1ns
module sobel_top import sobel_pkg::*;
(
  input  logic   sys_clk,
  input  logic   sys_rst_n,
  input  pixel_t pix_in,
  input  logic   pix_valid,   // raster order, gaps allowed
  input  logic   cfg_we,
  input  logic   cfg_addr,
  input  pixel_t cfg_wdata,
  output pixel_t pix_out,     // BLACK or WHITE
  output logic   out_valid    // pix_valid of window corner + 4
);

  edge_cfg_t cfg;
  column_t   col;
  logic      col_valid;

  // threshold and polarity
  edge_cfg_regs edge_cfg_regs_i (
    .sys_clk   (sys_clk),
    .sys_rst_n (sys_rst_n),
    .cfg_we    (cfg_we),
    .cfg_addr  (cfg_addr),
    .cfg_wdata (cfg_wdata),
    .cfg       (cfg)
  );

  // two-row history, one column out per pixel
  line_buffer line_buffer_i (
    .sys_clk   (sys_clk),
    .sys_rst_n (sys_rst_n),
    .pix_in    (pix_in),
    .pix_valid (pix_valid),
    .col       (col),
    .col_valid (col_valid)
  );

  sobel_kernel sobel_kernel_i (
    .sys_clk   (sys_clk),
    .sys_rst_n (sys_rst_n),
    .col       (col),
    .col_valid (col_valid),
    .cfg       (cfg),
    .pix_out   (pix_out),
    .out_valid (out_valid)
  );

endmodule

// ==== sobel_checker.sv ====
`timescale 1ns/1ns
module sobel_checker import sobel_pkg::*;
(
  input logic   sys_clk,
  input logic   sys_rst_n,
  input logic   wr_en,       // fifo side, tied low on the top level
  input logic   rd_en,
  input logic   full,
  input logic   empty,
  input logic   out_valid,   // top side, tied low on the fifos
  input pixel_t pix_out
);

  int fail_count = 0;        // failures seen so far

  no_overflow: assert property (@(posedge sys_clk) disable iff (!sys_rst_n)
    !(wr_en && full))
  else
  begin
    fail_count++;
    $error("line fifo written while full");
  end

  no_underflow: assert property (@(posedge sys_clk) disable iff (!sys_rst_n)
    !(rd_en && empty))
  else
  begin
    fail_count++;
    $error("line fifo read while empty");
  end

  // async reset clears the strobe at once
  quiet_in_reset: assert property (@(posedge sys_clk) !sys_rst_n |-> !out_valid)
  else
  begin
    fail_count++;
    $error("out_valid high during reset");
  end

  two_colours: assert property (@(posedge sys_clk) disable iff (!sys_rst_n)
    out_valid |-> (pix_out == BLACK || pix_out == WHITE))
  else
  begin
    fail_count++;
    $error("pix_out is neither black nor white");
  end

endmodule

bind line_fifo sobel_checker fifo_chk (
  .sys_clk   (sys_clk),
  .sys_rst_n (sys_rst_n),
  .wr_en     (wr_en),
  .rd_en     (rd_en),
  .full      (full),
  .empty     (empty),
  .out_valid (1'b0),
  .pix_out   (8'h00)
);

bind sobel_top sobel_checker top_chk (
  .sys_clk   (sys_clk),
  .sys_rst_n (sys_rst_n),
  .wr_en     (1'b0),
  .rd_en     (1'b0),
  .full      (1'b0),
  .empty     (1'b0),
  .out_valid (out_valid),
  .pix_out   (pix_out)
);

// ==== tb_sobel.sv ====
`timescale 1ns/1ns
module tb_sobel import sobel_pkg::*;
();

  localparam int MAX_GAP     = 5;          // idle cycles between pixels, worst case
  localparam int NUM_FRAMES  = 14;         // all tests together
  localparam int WATCHDOG_NS = NUM_FRAMES * IMG_W * IMG_H * (MAX_GAP + 1) * 8 + 20000;
  localparam int DRAIN_LIMIT = 100;
  localparam int KIND_RANDOM = 0;
  localparam int KIND_FLAT   = 1;
  localparam int KIND_BLOCKS = 2;          // 2x2 checkerboard of BLACK and WHITE

  logic   sys_clk = 1'b0;
  logic   sys_rst_n;
  pixel_t pix_in;
  logic   pix_valid;
  logic   cfg_we;
  logic   cfg_addr;
  pixel_t cfg_wdata;
  pixel_t pix_out;
  logic   out_valid;

  int          seed = 32'hd93b_19b6;
  int unsigned cyc = 0;                    // posedge count, stable at negedge
  int          errors = 0;
  int          checks = 0;
  int          tests = 0;
  int          out_count = 0;
  int          model_thr = int'(DEF_THRESHOLD);
  logic        model_white = 1'b0;
  pixel_t      frame [IMG_H][IMG_W];
  pixel_t      exp_q [$];                  // expected pixels, raster order of centres
  int unsigned time_q [$];                 // strobe cycle of each window's last pixel

  always #4 sys_clk = ~sys_clk;
  always @(posedge sys_clk) cyc <= cyc + 1;

  sobel_top sobel_top_i (
    .sys_clk   (sys_clk),
    .sys_rst_n (sys_rst_n),
    .pix_in    (pix_in),
    .pix_valid (pix_valid),
    .cfg_we    (cfg_we),
    .cfg_addr  (cfg_addr),
    .cfg_wdata (cfg_wdata),
    .pix_out   (pix_out),
    .out_valid (out_valid)
  );

  task automatic check_val(input string name, input logic [31:0] got, input logic [31:0] expected);
    checks++;
    if (got !== expected)
    begin
      errors++;
      $display("error %s got 0x%0h expected 0x%0h at %0t ns", name, got, expected, $time);
    end
  endtask

  function automatic int rand_below(input int n);
    logic [31:0] r;
    r = $random(seed);
    return int'(r % 32'(n));
  endfunction

  // a + 2b + c down one column / along one row
  function automatic int col_weight(input int r, input int c);
    return int'(frame[r - 1][c]) + 2 * int'(frame[r][c]) + int'(frame[r + 1][c]);
  endfunction

  function automatic int row_weight(input int r, input int c);
    return int'(frame[r][c - 1]) + 2 * int'(frame[r][c]) + int'(frame[r][c + 1]);
  endfunction

  task automatic fill_frame(input int kind);
    pixel_t level;
    level = pixel_t'(rand_below(256));     // flat frames only
    for (int r = 0; r < IMG_H; r++)
      for (int c = 0; c < IMG_W; c++)
        case (kind)
          KIND_FLAT:   frame[r][c] = level;
          KIND_BLOCKS: frame[r][c] = (((r / 2) + (c / 2)) % 2 == 1) ? WHITE : BLACK;
          default:     frame[r][c] = pixel_t'(rand_below(256));
        endcase
  endtask

  // reference model, interior pixels only
  task automatic predict_frame();
    int gx;
    int gy;
    int mag;
    for (int r = 1; r < IMG_H - 1; r++)
      for (int c = 1; c < IMG_W - 1; c++)
      begin
        gx  = col_weight(r, c - 1) - col_weight(r, c + 1);   // left minus right
        gy  = row_weight(r - 1, c) - row_weight(r + 1, c);   // top minus bottom
        mag = (gx < 0 ? -gx : gx) + (gy < 0 ? -gy : gy);
        if (mag >= model_thr)
          exp_q.push_back(model_white ? WHITE : BLACK);
        else
          exp_q.push_back(model_white ? BLACK : WHITE);
      end
  endtask

  // leaves pix_valid high on the last pixel so frames can run back to back
  task automatic send_frame(input int max_gap);
    int gap;
    for (int r = 0; r < IMG_H; r++)
      for (int c = 0; c < IMG_W; c++)
      begin
        gap = (max_gap > 0) ? rand_below(max_gap + 1) : 0;
        repeat (gap)
        begin
          @(negedge sys_clk);
          pix_valid = 1'b0;
        end
        @(negedge sys_clk);
        pix_valid = 1'b1;
        pix_in    = frame[r][c];
        if (r >= 2 && c >= 2)
          time_q.push_back(cyc);           // bottom-right corner of a window
      end
  endtask

  task automatic drain();
    int waited;
    waited = 0;
    @(negedge sys_clk);
    pix_valid = 1'b0;
    while (exp_q.size() != 0 && waited < DRAIN_LIMIT)
    begin
      @(negedge sys_clk);
      waited++;
    end
    if (exp_q.size() != 0)
    begin
      errors++;
      $display("%0d expected output pixels never appeared", exp_q.size());
      exp_q.delete();
      time_q.delete();
    end
    repeat (8) @(negedge sys_clk);         // room for stray strobes
  endtask

  task automatic write_cfg(input logic addr, input pixel_t data);
    @(negedge sys_clk);
    cfg_we    = 1'b1;
    cfg_addr  = addr;
    cfg_wdata = data;
    @(negedge sys_clk);
    cfg_we = 1'b0;
    if (addr == CFG_ADDR_THRESH)
      model_thr = int'(data);
    else
      model_white = data[0];               // rest of the byte ignored
  endtask

  task automatic run_frames(input int n, input int kind, input int max_gap, input bit b2b);
    int start_count;
    start_count = out_count;
    for (int f = 0; f < n; f++)
    begin
      fill_frame(kind);
      predict_frame();
      send_frame(max_gap);
      if (!b2b)
        drain();
    end
    if (b2b)
      drain();
    check_val("output count", 32'(out_count - start_count),
              32'(n * (IMG_W - 2) * (IMG_H - 2)));
  endtask

  task automatic finish_test(input string name, input int err_start);
    tests++;
    $display("test %0d %s: %s, %0d errors", tests, name,
             (errors == err_start) ? "pass" : "fail", errors - err_start);
  endtask

  // output monitor, values and latency
  always @(negedge sys_clk)
  begin
    if (sys_rst_n && out_valid)
    begin
      if (exp_q.size() == 0 || time_q.size() == 0)
      begin
        errors++;
        $display("out_valid rose with no output pending at %0t ns", $time);
      end
      else
      begin
        check_val("pix_out", 32'(pix_out), 32'(exp_q.pop_front()));
        check_val("out_valid delay", cyc - time_q.pop_front(), 32'd4);
        out_count++;
      end
    end
  end

  initial
  begin
    #(WATCHDOG_NS);
    $display("timeout after %0d ns, the DUT stopped producing output", WATCHDOG_NS);
    $display("CHECKS FAILED");
    $finish;
  end

  initial
  begin
    int err_start;
    sys_rst_n = 1'b1;
    pix_in    = '0;
    pix_valid = 1'b0;
    cfg_we    = 1'b0;
    cfg_addr  = 1'b0;
    cfg_wdata = '0;
    #1 sys_rst_n = 1'b0;                   // clean falling edge before the first clock
    err_start = errors;
    repeat (3)
    begin
      @(negedge sys_clk);
      check_val("out_valid", 32'(out_valid), 32'h0);
    end
    sys_rst_n = 1'b1;
    run_frames(1, KIND_RANDOM, 0, 1'b0);   // early strobes caught by the latency check
    finish_test("reset and first rows", err_start);

    err_start = errors;
    run_frames(3, KIND_RANDOM, 0, 1'b0);
    finish_test("unbroken stream, default threshold", err_start);

    err_start = errors;
    run_frames(3, KIND_RANDOM, MAX_GAP, 1'b0);
    finish_test("random gaps", err_start);

    err_start = errors;
    write_cfg(CFG_ADDR_THRESH, pixel_t'(rand_below(256)));
    write_cfg(CFG_ADDR_MODE, pixel_t'(rand_below(128) * 2 + 1) | 8'h80);
    run_frames(2, KIND_RANDOM, MAX_GAP, 1'b0);
    finish_test("threshold and white edges", err_start);

    err_start = errors;
    write_cfg(CFG_ADDR_MODE, 8'hfe);       // back to black edges
    write_cfg(CFG_ADDR_THRESH, 8'd1);
    run_frames(1, KIND_FLAT, 2, 1'b0);     // all background
    write_cfg(CFG_ADDR_THRESH, 8'd255);
    run_frames(1, KIND_BLOCKS, 2, 1'b0);   // magnitudes up to 1020 and beyond 255
    write_cfg(CFG_ADDR_THRESH, 8'd0);
    run_frames(1, KIND_RANDOM, 2, 1'b0);   // all edge
    finish_test("edge cases", err_start);

    err_start = errors;
    write_cfg(CFG_ADDR_THRESH, DEF_THRESHOLD);
    run_frames(2, KIND_RANDOM, 0, 1'b1);
    finish_test("back-to-back frames", err_start);

    // assertion failures from the bound checkers
    errors += sobel_top_i.top_chk.fail_count;
    errors += sobel_top_i.line_buffer_i.fifo_mid.fifo_chk.fail_count;
    errors += sobel_top_i.line_buffer_i.fifo_top.fifo_chk.fail_count;
    $display("summary: %0d tests, %0d checks, %0d outputs, %0d errors",
             tests, checks, out_count, errors);
    if (errors == 0)
      $display("ALL CHECKS PASSED");
    else
      $display("CHECKS FAILED");
    $finish;
  end

endmodule

// ==== all.f ====
sobel_pkg.sv
line_fifo.sv
line_buffer.sv
sobel_kernel.sv
edge_cfg_regs.sv
sobel_top.sv
sobel_checker.sv
tb_sobel.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# build and run the Sobel testbench with Verilator
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert -Wno-fatal -f all.f --top-module tb_sobel -o sim_tb
status=0
./obj_dir/sim_tb +verilator+error+limit+100 > sim.log 2>&1 || status=$?
cat sim.log
if grep -q "CHECKS FAILED" sim.log || [ "$status" -ne 0 ]; then
  echo "simulation failed"
  exit 1
fi
echo "simulation passed"
